//--- serial_divider_pkg.sv
/*
  Shared types for the serial radix-2 divider.
  Operand width is fixed at 32 bits; the shift logic depends on it.
  Opcode bit 0 selects signed, bit 1 selects remainder.
*/
`default_nettype none

package serial_divider_pkg;

  // Operand width and iteration counter width
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned ShiftWidth = 6;

  typedef logic [DataWidth-1:0]  word_t;
  typedef logic [ShiftWidth-1:0] shift_t;
  typedef logic [1:0]            op_code_t;

  // RISC-V M divide and remainder opcodes
  localparam op_code_t OpDivu = 2'd0;
  localparam op_code_t OpDiv  = 2'd1;
  localparam op_code_t OpRemu = 2'd2;
  localparam op_code_t OpRem  = 2'd3;

  // Iteration core states
  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } div_state_e;

  // Request as seen on the top-level port
  typedef struct packed {
    op_code_t op;
    word_t    a;
    word_t    b;
  } div_req_t;

  // Prepared job, divisor already aligned by the shift
  typedef struct packed {
    word_t  dividend;
    word_t  divisor;
    shift_t shift;
    logic   b_sign;
    logic   b_zero;
    logic   rem_sel;
    logic   res_neg;
  } div_job_t;

  // Raw core result before selection and sign fix
  typedef struct packed {
    word_t rem;
    word_t quot_rev;
    logic  rem_sel;
    logic  res_neg;
  } div_raw_t;

endpackage

`default_nettype wire

//--- div_operand_prep.sv
/*
  Purely combinational job preparation for the divider core.
  Shift is 32 for a zero divisor, which gives 33 iterations.
  Negative divisors keep one sign bit after alignment.
*/
`timescale 1ns/10ps
`default_nettype none

module div_operand_prep (
  input  serial_divider_pkg::div_req_t req,
  output serial_divider_pkg::div_job_t job
);

  ////////////////////////////////////////////////////////////
  // Sign and leading bit count
  ////////////////////////////////////////////////////////////

  logic                       is_signed;
  logic                       b_sign;
  logic                       a_sign;
  logic                       b_zero;
  serial_divider_pkg::word_t  lead_x;
  serial_divider_pkg::shift_t lead;
  serial_divider_pkg::shift_t shift;

  always_comb begin
    is_signed = req.op[0];
    // Sign bits only count for signed opcodes
    b_sign    = is_signed & req.b[serial_divider_pkg::DataWidth-1];
    a_sign    = is_signed & req.a[serial_divider_pkg::DataWidth-1];
    b_zero    = (req.b == '0);

    // Leading bits equal to the sign become leading zeros here
    lead_x = req.b ^ {serial_divider_pkg::DataWidth{b_sign}};

    // Highest set bit wins, all zero means the full width
    lead = serial_divider_pkg::shift_t'(serial_divider_pkg::DataWidth);
    for (int i = 0; i < serial_divider_pkg::DataWidth; i++) begin
      if (lead_x[i]) begin
        lead = serial_divider_pkg::shift_t'(serial_divider_pkg::DataWidth - 1 - i);
      end
    end

    // Negative divisor keeps its sign bit at the top
    // Non-negative divisor is aligned to the MSB
    shift = lead - serial_divider_pkg::shift_t'(b_sign);
  end

  ////////////////////////////////////////////////////////////
  // Job fields
  ////////////////////////////////////////////////////////////

  always_comb begin
    job.dividend = req.a;
    // Early termination, divisor starts already aligned
    job.divisor  = req.b << shift;
    job.shift    = shift;
    job.b_sign   = b_sign;
    job.b_zero   = b_zero;
    job.rem_sel  = req.op[1];
    // Differing signs negate the result
    // Quotient by zero stays all ones, so no negate there
    job.res_neg  = (a_sign ^ b_sign) & (~b_zero | req.op[1]);
  end

endmodule

`default_nettype wire

//--- div_iter_core.sv
/*
  Iterative divide core, one quotient bit per DIVIDE cycle.
  start is honoured only in IDLE; raw_vld is a one-cycle strobe.
  Takes shift+1 DIVIDE cycles plus one FINISH cycle.
  Quotient register comes out bit-reversed.
*/
`timescale 1ns/10ps
`default_nettype none

module div_iter_core (
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  input  logic                         start,
  input  serial_divider_pkg::div_job_t job,
  output logic                         busy,
  output logic                         raw_vld,
  output serial_divider_pkg::div_raw_t raw
);

  serial_divider_pkg::div_state_e state_q;
  serial_divider_pkg::div_state_e state_d;
  serial_divider_pkg::shift_t     cnt_q;
  serial_divider_pkg::shift_t     cnt_d;

  // Partial remainder, aligned divisor, reversed quotient
  serial_divider_pkg::word_t a_q;
  serial_divider_pkg::word_t b_q;
  serial_divider_pkg::word_t q_q;

  // Job flags held for the whole operation
  logic b_sign_q;
  logic b_zero_q;
  logic rem_sel_q;
  logic res_neg_q;

  logic                      load;
  logic                      iter;
  logic                      cnt_zero;
  logic                      ab_comp;
  logic                      add_sub;
  serial_divider_pkg::word_t add_a;
  serial_divider_pkg::word_t add_b;
  serial_divider_pkg::word_t add_out;

  ////////////////////////////////////////////////////////////
  // Shared adder and compare
  ////////////////////////////////////////////////////////////

  assign load     = (state_q == serial_divider_pkg::IDLE) & start;
  assign iter     = (state_q == serial_divider_pkg::DIVIDE);
  assign cnt_zero = (cnt_q == '0);

  // Load brings the dividend to the divisor's sign
  // That is exactly when the final result gets negated
  // (zero divisor quotient does not care about A)
  assign add_a   = load ? '0 : a_q;
  assign add_b   = load ? job.dividend : b_q;
  assign add_sub = load ? job.res_neg : 1'b1;
  assign add_out = add_sub ? (add_a - add_b) : (add_a + add_b);

  // |A| >= |B| for same-signed A and B
  // Unsigned order flips for negative operands
  // A of zero never subtracts, except on divide by zero
  assign ab_comp = ((a_q == b_q) | ((a_q > b_q) ^ b_sign_q)) & ((|a_q) | b_zero_q);

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      serial_divider_pkg::IDLE: begin
        if (start) begin
          state_d = serial_divider_pkg::DIVIDE;
          cnt_d   = job.shift;
        end
      end
      serial_divider_pkg::DIVIDE: begin
        // Last bit is the one with weight 2^0
        if (cnt_zero) begin
          state_d = serial_divider_pkg::FINISH;
        end else begin
          cnt_d = cnt_q - serial_divider_pkg::shift_t'(1);
        end
      end
      serial_divider_pkg::FINISH: begin
        state_d = serial_divider_pkg::IDLE;
      end
      default: begin
        state_d = serial_divider_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q <= serial_divider_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI) begin
    if (load) begin
      a_q       <= add_out;
      b_q       <= job.divisor;
      q_q       <= '0;
      b_sign_q  <= job.b_sign;
      b_zero_q  <= job.b_zero;
      rem_sel_q <= job.rem_sel;
      res_neg_q <= job.res_neg;
    end else if (iter) begin
      if (ab_comp) begin
        a_q <= add_out;
      end
      // Arithmetic shift keeps a negative divisor exact
      b_sg_shift: begin
        b_q <= {b_sign_q, b_q[serial_divider_pkg::DataWidth-1:1]};
      end
      // New bit enters at the top, reversed later
      q_q <= {ab_comp, q_q[serial_divider_pkg::DataWidth-1:1]};
    end
  end

  // Outputs
  assign busy    = (state_q != serial_divider_pkg::IDLE);
  assign raw_vld = (state_q == serial_divider_pkg::FINISH);

  always_comb begin
    raw.rem      = a_q;
    raw.quot_rev = q_q;
    raw.rem_sel  = rem_sel_q;
    raw.res_neg  = res_neg_q;
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Top level must hold off start until busy drops
  a_start_idle: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    start |-> (state_q == serial_divider_pkg::IDLE));

  // FINISH always falls back to IDLE
  a_raw_pulse: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    raw_vld |=> !raw_vld);

  // Counter only runs downward while iterating
  a_cnt_down: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (state_q == serial_divider_pkg::DIVIDE) |=> (cnt_q <= $past(cnt_q)));

endmodule

`default_nettype wire

//--- div_result_fix.sv
/*
  Result stage: picks quotient or remainder and fixes its sign.
  One cycle from raw_vld to done; result holds until the next done.
*/
`timescale 1ns/10ps
`default_nettype none

module div_result_fix (
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  input  logic                         raw_vld,
  input  serial_divider_pkg::div_raw_t raw,
  output logic                         done,
  output serial_divider_pkg::word_t    result
);

  serial_divider_pkg::word_t quot;
  serial_divider_pkg::word_t sel;
  serial_divider_pkg::word_t fixed;

  always_comb begin
    // Core builds the quotient MSB-first from the top
    for (int i = 0; i < serial_divider_pkg::DataWidth; i++) begin
      quot[i] = raw.quot_rev[serial_divider_pkg::DataWidth-1-i];
    end

    sel = raw.rem_sel ? raw.rem : quot;

    // Two's complement negate
    fixed = raw.res_neg ? (~sel + serial_divider_pkg::word_t'(1)) : sel;
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= raw_vld;
      if (raw_vld) begin
        result <= fixed;
      end
    end
  end

  // Core FINISH is a single cycle, so done is a single pulse
  a_done_pulse: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    done |=> !done);

endmodule

`default_nettype wire

//--- serial_divider.sv
/*
  Serial 32-bit divider with RISC-V M semantics.
  start is a one-cycle strobe, legal only while busy is low.
  done pulses once per start, at most 36 cycles later.
  A new start may be issued in the cycle of done.
*/
`timescale 1ns/10ps
`default_nettype none

module serial_divider (
  input  logic                         Clk_CI,
  input  logic                         Rst_RBI,
  input  logic                         start,
  input  serial_divider_pkg::div_req_t req,
  output logic                         busy,
  output logic                         done,
  output serial_divider_pkg::word_t    result
);

  ////////////////////////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////////////////////////

  // Prepared job, valid in the start cycle
  serial_divider_pkg::div_job_t job;

  // Raw core result, valid with raw_vld
  serial_divider_pkg::div_raw_t raw;
  logic                         raw_vld;

  // Shift, zero and sign flags
  div_operand_prep div_operand_prep_inst (
    .req (req),
    .job (job)
  );

  // Iterative quotient and remainder
  div_iter_core div_iter_core_inst (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (start),
    .job     (job),
    .busy    (busy),
    .raw_vld (raw_vld),
    .raw     (raw)
  );

  // Select, sign fix and output register
  div_result_fix div_result_fix_inst (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .raw_vld (raw_vld),
    .raw     (raw),
    .done    (done),
    .result  (result)
  );

endmodule

`default_nettype wire

//--- tb_div_checks.svh
/*
  Reference model and compare tasks, included inside the testbench module.
  Model follows RISC-V M rules for 32-bit divide and remainder.
*/
`ifndef TB_DIV_CHECKS_SVH
`define TB_DIV_CHECKS_SVH

// Totals for the closing summary
int check_count   = 0;
int error_count   = 0;
int timeout_count = 0;

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

function automatic serial_divider_pkg::word_t expected_word(
  input serial_divider_pkg::op_code_t op,
  input serial_divider_pkg::word_t    a,
  input serial_divider_pkg::word_t    b
);
  logic                      is_signed;
  logic                      want_rem;
  serial_divider_pkg::word_t quot;
  serial_divider_pkg::word_t rem;
  int                        sa;
  int                        sb;
  is_signed = op[0];
  want_rem  = op[1];
  sa        = a;
  sb        = b;
  if (b == '0) begin
    // Divide by zero
    quot = '1;
    rem  = a;
  end else if (is_signed && (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF)) begin
    // Signed overflow
    quot = a;
    rem  = '0;
  end else if (is_signed) begin
    // Truncation toward zero, remainder follows the dividend
    quot = serial_divider_pkg::word_t'(sa / sb);
    rem  = serial_divider_pkg::word_t'(sa % sb);
  end else begin
    quot = a / b;
    rem  = a % b;
  end
  return want_rem ? rem : quot;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_result(
  input string                     name,
  input serial_divider_pkg::word_t exp,
  input serial_divider_pkg::word_t act
);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("[FAIL] %0t: %s expected %h, actual %h", $time, name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("[FAIL] %0t: %s expected %b, actual %b", $time, name, exp, act);
  end
endtask

`endif

//--- tb_serial_divider.sv
/*
  Testbench for the serial divider, random stimulus from a fixed seed.
  Inputs change 5 ns after each rising edge, outputs are sampled there too.
  Every wait for done gives up after 64 cycles.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_serial_divider;

  localparam int ClkHalf     = 50;
  localparam int DriveDelay  = 5;
  localparam int ResetCycles = 16;
  localparam int DoneTimeout = 64;

  logic                         Clk_CI;
  logic                         Rst_RBI;
  logic                         start;
  serial_divider_pkg::div_req_t req;
  logic                         busy;
  logic                         done;
  serial_divider_pkg::word_t    result;

  int   seed;
  logic timed_out;

  `include "tb_div_checks.svh"

  serial_divider serial_divider_inst (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (start),
    .req     (req),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  // 100 ns clock
  initial begin
    Clk_CI = 1'b0;
    forever #ClkHalf Clk_CI = ~Clk_CI;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge Clk_CI);
    #DriveDelay;
  endtask

  // Quiet cycles between operations
  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      if (!timed_out) begin
        next_cycle();
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
      end
    end
  endtask

  // Mix of short and long divisor shifts
  function automatic serial_divider_pkg::word_t biased_word();
    int unsigned               sel;
    serial_divider_pkg::word_t rnd;
    serial_divider_pkg::word_t w;
    sel = $unsigned($random(seed)) % 5;
    rnd = $random(seed);
    case (sel)
      0: w = rnd & 32'h0000_000F;
      1: w = rnd & 32'h0000_FFFF;
      2: w = rnd | 32'h8000_0000;
      3: w = 32'h1 << rnd[4:0];
      default: w = rnd;
    endcase
    return w;
  endfunction

  function automatic serial_divider_pkg::word_t corner_word(input int k);
    serial_divider_pkg::word_t w;
    case (k)
      0: w = 32'h0000_0000;
      1: w = 32'h0000_0001;
      2: w = 32'h8000_0000;
      3: w = 32'hFFFF_FFFF;
      4: w = 32'h7FFF_FFFF;
      default: w = $random(seed);
    endcase
    return w;
  endfunction

  // Issue one start, follow busy, wait for done and check the result
  // Returns in the done cycle, so a following call starts back to back
  task automatic run_op(
    input serial_divider_pkg::op_code_t op,
    input serial_divider_pkg::word_t    a,
    input serial_divider_pkg::word_t    b
  );
    serial_divider_pkg::word_t expected;
    int                        waited;
    logic                      seen_done;
    if (timed_out) return;
    expected = expected_word(op, a, b);
    start    = 1'b1;
    req.op   = op;
    req.a    = a;
    req.b    = b;
    next_cycle();
    start = 1'b0;
    // Operands are only sampled with start
    req.a = $random(seed);
    req.b = $random(seed);
    check_flag("busy", 1'b1, busy);
    check_flag("done", 1'b0, done);
    waited    = 0;
    seen_done = 1'b0;
    while (!seen_done && (waited < DoneTimeout)) begin
      next_cycle();
      waited++;
      if (done) begin
        seen_done = 1'b1;
      end else begin
        check_flag("busy", 1'b1, busy);
      end
    end
    if (!seen_done) begin
      $display("Timeout: done did not arrive within %0d cycles (op %0d, a %h, b %h)",
               DoneTimeout, op, a, b);
      timeout_count++;
      timed_out = 1'b1;
    end else begin
      check_result("result", expected, result);
      check_flag("busy", 1'b0, busy);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    serial_divider_pkg::word_t a;
    serial_divider_pkg::word_t b;
    seed      = 32'h61f83cf6;
    timed_out = 1'b0;
    Rst_RBI   = 1'b0;
    start     = 1'b0;
    req       = '0;
    repeat (ResetCycles) @(posedge Clk_CI);
    #DriveDelay;
    Rst_RBI = 1'b1;

    // Reset state
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    check_result("result", '0, result);
    idle_cycles(2);

    // Unsigned quotient and remainder
    for (int i = 0; i < 300; i++) begin
      a = $random(seed);
      b = biased_word();
      run_op(i[0] ? serial_divider_pkg::OpRemu : serial_divider_pkg::OpDivu, a, b);
    end

    // Signed, cycling through all sign combinations
    for (int i = 0; i < 300; i++) begin
      a = biased_word() & 32'h7FFF_FFFF;
      b = biased_word() & 32'h7FFF_FFFF;
      a = i[0] ? -a : a;
      b = i[1] ? -b : b;
      run_op(i[2] ? serial_divider_pkg::OpRem : serial_divider_pkg::OpDiv, a, b);
    end

    // Zero divisor with every opcode
    for (int k = 0; k < 8; k++) begin
      a = corner_word(k);
      for (int op = 0; op < 4; op++) begin
        run_op(serial_divider_pkg::op_code_t'(op), a, '0);
      end
    end

    // Overflow case and unit divisors
    run_op(serial_divider_pkg::OpDiv, 32'h8000_0000, 32'hFFFF_FFFF);
    run_op(serial_divider_pkg::OpRem, 32'h8000_0000, 32'hFFFF_FFFF);
    for (int k = 0; k < 8; k++) begin
      a = corner_word(k);
      for (int op = 0; op < 4; op++) begin
        run_op(serial_divider_pkg::op_code_t'(op), a, 32'h0000_0001);
        run_op(serial_divider_pkg::op_code_t'(op), a, 32'hFFFF_FFFF);
      end
    end

    // Random opcodes with idle gaps in between
    for (int i = 0; i < 100; i++) begin
      a = $random(seed);
      b = biased_word();
      run_op(serial_divider_pkg::op_code_t'($unsigned($random(seed)) % 4), a, b);
      idle_cycles($unsigned($random(seed)) % 4);
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- serial_divider.f
+incdir+.
serial_divider_pkg.sv
div_operand_prep.sv
div_iter_core.sv
div_result_fix.sv
serial_divider.sv
tb_serial_divider.sv

//--- Makefile
# Verilator build and run for the serial divider testbench
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_serial_divider
FILELIST  ?= serial_divider.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

# Build, run, then judge the run from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
